/* include/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Datapath sizes
`define CONV_BIT_WIDTH        8
`define CONV_NUM_CHANNEL      3
`define CONV_NUM_KERNEL       4
`define CONV_NUM_KCPE         3
`define CONV_PSUM_WIDTH       16

// Line width field, 1 to 255 pixels
`define CONV_LINE_WIDTH_BITS  8

`endif

/* src/conv_types_pkg.sv */
`include "conv_macros.svh"

package conv_types_pkg;

    ////////////////////////////////////////
    // Pixel data

    // One signed channel value
    typedef logic signed [`CONV_BIT_WIDTH-1:0] chan_t;

    // Channel c in bits [8c+7:8c]
    typedef chan_t [`CONV_NUM_CHANNEL-1:0] pixel_t;

    // Slot 0 holds the newest pixel
    typedef pixel_t [`CONV_NUM_KCPE-1:0] tap_window_t;

    ////////////////////////////////////////
    // Weights

    // One tap for every kernel, kernel n in group n
    typedef pixel_t [`CONV_NUM_KERNEL-1:0] weight_word_t;

    // One weight word per window slot
    typedef weight_word_t [`CONV_NUM_KCPE-1:0] tap_weights_t;

    ////////////////////////////////////////
    // Partial sums

    typedef logic signed [`CONV_PSUM_WIDTH-1:0] psum_t;
    typedef psum_t [`CONV_NUM_KERNEL-1:0] psum_bundle_t;

endpackage

/* src/conv_cfg_pkg.sv */
`include "conv_macros.svh"

package conv_cfg_pkg;

    // Held stable from start until done
    typedef struct packed {
        logic [`CONV_LINE_WIDTH_BITS-1:0] line_width;
        logic [1:0]                       kernel_width;
    } conv_cfg_t;

    // Controller phases
    typedef enum logic [1:0] {
        IDLE,
        WEIGHT,
        DATA,
        DRAIN
    } ctrl_phase_t;

endpackage

/* src/conv_controller.sv */
`timescale 1ns/1ns

`include "conv_macros.svh"

module conv_controller (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_start,
    input  conv_cfg_pkg::conv_cfg_t i_cfg,
    input  logic                    i_weight_vld,
    input  logic                    i_data_vld,
    input  logic                    i_line_end,
    output logic                    o_weight_req,
    output logic                    o_data_req,
    output logic                    o_weight_we,
    output logic [1:0]              o_weight_slot,
    output logic                    o_clear,
    output logic                    o_shift,
    output logic                    o_done
);
    import conv_cfg_pkg::*;

    ctrl_phase_t                      phase;
    logic [1:0]                       tap_cnt;
    logic [`CONV_LINE_WIDTH_BITS-1:0] pix_cnt;
    logic                             last_tap;
    logic                             last_pix;

    ////////////////////////////////////////
    // Strobe decoding

    // Start is honoured only between lines, done is only ever set in IDLE
    assign o_clear = i_start && (phase == IDLE);

    assign o_weight_req = (phase == WEIGHT);
    assign o_data_req   = (phase == DATA);

    assign o_weight_we = i_weight_vld && (phase == WEIGHT);
    assign o_shift     = i_data_vld && (phase == DATA);

    // Tap t lands in slot kernel_width-1-t
    assign o_weight_slot = i_cfg.kernel_width - 2'd1 - tap_cnt;

    assign last_tap = (tap_cnt == i_cfg.kernel_width - 2'd1);
    assign last_pix = (pix_cnt == i_cfg.line_width - 1'b1);

    ////////////////////////////////////////
    // Phase register and counters

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= IDLE;
            tap_cnt <= '0;
            pix_cnt <= '0;
            o_done  <= 1'b0;
        end else if (o_clear) begin
            phase   <= WEIGHT;
            tap_cnt <= '0;
            pix_cnt <= '0;
            o_done  <= 1'b0;
        end else begin
            case (phase)
                WEIGHT: begin
                    if (o_weight_we) begin
                        if (last_tap) begin
                            phase <= DATA;
                        end else begin
                            tap_cnt <= tap_cnt + 2'd1;
                        end
                    end
                end
                DATA: begin
                    // Last pixel accepted, wait for the pipeline to empty
                    if (o_shift) begin
                        if (last_pix) begin
                            phase <= DRAIN;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (i_line_end) begin
                        phase  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

endmodule

/* src/weight_buffer.sv */
`timescale 1ns/1ns

`include "conv_macros.svh"

module weight_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_clear,
    input  logic                         i_we,
    input  logic [1:0]                   i_slot,
    input  conv_types_pkg::weight_word_t i_weight,
    output conv_types_pkg::tap_weights_t o_weights
);

    logic slot_ok;

    // Slot 3 does not exist
    assign slot_ok = (i_slot < 2'(`CONV_NUM_KCPE));

    ////////////////////////////////////////
    // Tap registers

    // Unwritten slots stay zero, so short kernels need no masking downstream
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            o_weights <= '0;
        end else if (i_we && slot_ok) begin
            o_weights[i_slot] <= i_weight;
        end
    end

endmodule

/* src/input_window.sv */
`timescale 1ns/1ns

module input_window (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_shift,
    input  conv_types_pkg::pixel_t      i_data,
    input  logic                        i_clear,
    output conv_types_pkg::tap_window_t o_window,
    output logic                        o_window_vld
);

    ////////////////////////////////////////
    // Pixel shift register

    // Newest pixel enters slot 0, oldest drops out of slot 2
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            o_window <= '0;
        end else if (i_shift) begin
            o_window <= {o_window[1], o_window[0], i_data};
        end
    end

    // One strobe per shift
    always_ff @(posedge clk) begin
        if (rst) begin
            o_window_vld <= 1'b0;
        end else begin
            o_window_vld <= i_shift;
        end
    end

endmodule

/* src/kernel_channel_pe.sv */
`timescale 1ns/1ns

`include "conv_macros.svh"

module kernel_channel_pe (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_vld,
    input  conv_types_pkg::pixel_t       i_pixel,
    input  conv_types_pkg::weight_word_t i_weight,
    output conv_types_pkg::psum_bundle_t o_psum,
    output logic                         o_psum_vld
);
    import conv_types_pkg::*;

    psum_bundle_t slot_sum;

    ////////////////////////////////////////
    // Channel MAC per kernel

    always_comb begin
        logic signed [2*`CONV_BIT_WIDTH-1:0] prod;
        psum_t                               acc;
        for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
            acc = '0;
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                prod = $signed(i_pixel[c]) * $signed(i_weight[n][c]);
                // Wraps at 16 bits
                acc = acc + prod;
            end
            slot_sum[n] = acc;
        end
    end

    always_ff @(posedge clk) begin
        o_psum <= slot_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_vld <= 1'b0;
        end else begin
            o_psum_vld <= i_vld;
        end
    end

endmodule

/* src/result_router.sv */
`timescale 1ns/1ns

`include "conv_macros.svh"

module result_router (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_clear,
    input  conv_cfg_pkg::conv_cfg_t      i_cfg,
    input  conv_types_pkg::psum_bundle_t i_psum_0,
    input  conv_types_pkg::psum_bundle_t i_psum_1,
    input  conv_types_pkg::psum_bundle_t i_psum_2,
    input  logic                         i_psum_vld,
    output conv_types_pkg::psum_bundle_t o_psum,
    output logic                         o_psum_vld,
    output logic                         o_psum_end,
    output logic                         o_line_end
);

    logic [`CONV_LINE_WIDTH_BITS-1:0] pos_cnt;
    logic [`CONV_LINE_WIDTH_BITS-1:0] kw_ext;
    logic                             covered;
    logic                             last_pos;

    ////////////////////////////////////////
    // Position tracking

    assign kw_ext = {{(`CONV_LINE_WIDTH_BITS-2){1'b0}}, i_cfg.kernel_width};

    // Kernel fully inside the line once kernel_width-1 pixels have passed
    assign covered  = (pos_cnt >= kw_ext - 1'b1);
    assign last_pos = (pos_cnt == i_cfg.line_width - 1'b1);

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            pos_cnt <= '0;
        end else if (i_psum_vld) begin
            pos_cnt <= last_pos ? '0 : pos_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Slot reduction per kernel

    always_ff @(posedge clk) begin
        for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
            o_psum[n] <= i_psum_0[n] + i_psum_1[n] + i_psum_2[n];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_vld <= 1'b0;
            o_psum_end <= 1'b0;
            o_line_end <= 1'b0;
        end else begin
            o_psum_vld <= i_psum_vld && covered;
            o_psum_end <= i_psum_vld && covered && last_pos;
            // Line end fires even for a line shorter than the kernel
            o_line_end <= i_psum_vld && last_pos;
        end
    end

endmodule

/* src/line_conv_engine.sv */
`timescale 1ns/1ns

module line_conv_engine (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_start,
    input  conv_cfg_pkg::conv_cfg_t      i_cfg,
    input  conv_types_pkg::weight_word_t i_weight,
    input  logic                         i_weight_vld,
    input  conv_types_pkg::pixel_t       i_data,
    input  logic                         i_data_vld,
    output logic                         o_weight_req,
    output logic                         o_data_req,
    output conv_types_pkg::psum_bundle_t o_psum,
    output logic                         o_psum_vld,
    output logic                         o_psum_end,
    output logic                         o_done
);
    import conv_types_pkg::*;

    logic         weight_we;
    logic [1:0]   weight_slot;
    logic         clear;
    logic         shift;
    logic         line_end;
    tap_weights_t weights;
    tap_window_t  window;
    logic         window_vld;
    psum_bundle_t kcpe_psum_0;
    psum_bundle_t kcpe_psum_1;
    psum_bundle_t kcpe_psum_2;
    logic         kcpe_vld;

    ////////////////////////////////////////
    // Control and storage

    conv_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_start       (i_start),
        .i_cfg         (i_cfg),
        .i_weight_vld  (i_weight_vld),
        .i_data_vld    (i_data_vld),
        .i_line_end    (line_end),
        .o_weight_req  (o_weight_req),
        .o_data_req    (o_data_req),
        .o_weight_we   (weight_we),
        .o_weight_slot (weight_slot),
        .o_clear       (clear),
        .o_shift       (shift),
        .o_done        (o_done)
    );

    weight_buffer u_wbuf (
        .clk       (clk),
        .rst       (rst),
        .i_clear   (clear),
        .i_we      (weight_we),
        .i_slot    (weight_slot),
        .i_weight  (i_weight),
        .o_weights (weights)
    );

    input_window u_win (
        .clk          (clk),
        .rst          (rst),
        .i_shift      (shift),
        .i_data       (i_data),
        .i_clear      (clear),
        .o_window     (window),
        .o_window_vld (window_vld)
    );

    ////////////////////////////////////////
    // One PE per window slot

    kernel_channel_pe kcpe_0 (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (window_vld),
        .i_pixel    (window[0]),
        .i_weight   (weights[0]),
        .o_psum     (kcpe_psum_0),
        .o_psum_vld (kcpe_vld)
    );

    // All slots share the strobe of slot 0
    kernel_channel_pe kcpe_1 (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (window_vld),
        .i_pixel    (window[1]),
        .i_weight   (weights[1]),
        .o_psum     (kcpe_psum_1),
        .o_psum_vld ()
    );

    kernel_channel_pe kcpe_2 (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (window_vld),
        .i_pixel    (window[2]),
        .i_weight   (weights[2]),
        .o_psum     (kcpe_psum_2),
        .o_psum_vld ()
    );

    result_router u_router (
        .clk        (clk),
        .rst        (rst),
        .i_clear    (clear),
        .i_cfg      (i_cfg),
        .i_psum_0   (kcpe_psum_0),
        .i_psum_1   (kcpe_psum_1),
        .i_psum_2   (kcpe_psum_2),
        .i_psum_vld (kcpe_vld),
        .o_psum     (o_psum),
        .o_psum_vld (o_psum_vld),
        .o_psum_end (o_psum_end),
        .o_line_end (line_end)
    );

endmodule

/* sim/tb_line_conv_engine.sv */
`timescale 1ns/1ns

`include "conv_macros.svh"

module tb_line_conv_engine;
    import conv_types_pkg::*;
    import conv_cfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 600;

    logic         clk;
    logic         rst;
    logic         i_start;
    conv_cfg_t    i_cfg;
    weight_word_t i_weight;
    logic         i_weight_vld;
    pixel_t       i_data;
    logic         i_data_vld;
    logic         o_weight_req;
    logic         o_data_req;
    psum_bundle_t o_psum;
    logic         o_psum_vld;
    logic         o_psum_end;
    logic         o_done;

    // Taps in tap order, pixels in line order
    weight_word_t taps [`CONV_NUM_KCPE];
    pixel_t       line_px [256];

    // Expected results and end markers, in output order
    psum_bundle_t exp_psum [$];
    bit           exp_end [$];

    int errors;
    int test_mark;
    int tests_run;
    int tests_failed;

    line_conv_engine UUT (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_cfg        (i_cfg),
        .i_weight     (i_weight),
        .i_weight_vld (i_weight_vld),
        .i_data       (i_data),
        .i_data_vld   (i_data_vld),
        .o_weight_req (o_weight_req),
        .o_data_req   (o_data_req),
        .o_psum       (o_psum),
        .o_psum_vld   (o_psum_vld),
        .o_psum_end   (o_psum_end),
        .o_done       (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Compare tasks

    task automatic check_psum(input string name, input psum_bundle_t got,
                              input psum_bundle_t want);
        for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
            if (got[n] !== want[n]) begin
                $display("error: t=%0t %s[%0d] got %h expected %h",
                         $time, name, n, got[n], want[n]);
                errors++;
            end
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("error: t=%0t %s got %b expected %b", $time, name, got, want);
            errors++;
        end
    endtask

    // Outputs are registered, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst) begin
            if (o_psum_vld === 1'b1) begin
                if (exp_psum.size() == 0) begin
                    $display("Result at t=%0t arrived while none was expected", $time);
                    errors++;
                end else begin
                    check_psum("o_psum", o_psum, exp_psum.pop_front());
                    check_flag("o_psum_end", o_psum_end, exp_end.pop_front());
                end
                // Done follows the end marker, never leads it
                if (o_psum_end === 1'b1) begin
                    check_flag("o_done", o_done, 1'b0);
                end
            end else begin
                check_flag("o_psum_end", o_psum_end, 1'b0);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic void fill_random();
        for (int t = 0; t < `CONV_NUM_KCPE; t++) begin
            for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
                for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                    taps[t][n][c] = chan_t'($urandom);
                end
            end
        end
        for (int x = 0; x < 256; x++) begin
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                line_px[x][c] = chan_t'($urandom);
            end
        end
    endfunction

    // Extremes of the channel range, so sums wrap
    function automatic void fill_extremes();
        for (int t = 0; t < `CONV_NUM_KCPE; t++) begin
            for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
                for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                    taps[t][n][c] = (n % 2 == 0) ? chan_t'(-128) : chan_t'(127);
                end
            end
        end
        for (int x = 0; x < 256; x++) begin
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                line_px[x][c] = (x % 3 == 2) ? chan_t'(127) : chan_t'(-128);
            end
        end
    endfunction

    // Reference convolution, one result per fully covered position
    function automatic void build_expected(input int lw, input int kw);
        psum_bundle_t bundle;
        int           acc;
        for (int x = 0; x <= lw - kw; x++) begin
            for (int n = 0; n < `CONV_NUM_KERNEL; n++) begin
                acc = 0;
                for (int t = 0; t < kw; t++) begin
                    for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                        acc += int'(line_px[x+t][c]) * int'(taps[t][n][c]);
                    end
                end
                bundle[n] = psum_t'(acc);
            end
            exp_psum.push_back(bundle);
            exp_end.push_back(x == lw - kw);
        end
    endfunction

    task automatic start_line(input int lw, input int kw);
        i_cfg.line_width   = 8'(lw);
        i_cfg.kernel_width = 2'(kw);
        i_start = 1'b1;
        tick();
        i_start = 1'b0;
    endtask

    task automatic load_weights(input int kw);
        int wait_cnt;
        wait_cnt = 0;
        while (o_weight_req !== 1'b1 && wait_cnt < TIMEOUT_CYCLES) begin
            tick();
            wait_cnt++;
        end
        if (o_weight_req !== 1'b1) begin
            $display("Timed out waiting for o_weight_req to rise");
            errors++;
            return;
        end
        for (int t = 0; t < kw; t++) begin
            i_weight     = taps[t];
            i_weight_vld = 1'b1;
            tick();
        end
        i_weight_vld = 1'b0;
        i_weight     = '0;
        // Request drops on the edge that takes the last tap
        check_flag("o_weight_req", o_weight_req, 1'b0);
    endtask

    task automatic send_line(input int lw, input bit gaps);
        int wait_cnt;
        int idle;
        wait_cnt = 0;
        while (o_data_req !== 1'b1 && wait_cnt < TIMEOUT_CYCLES) begin
            tick();
            wait_cnt++;
        end
        if (o_data_req !== 1'b1) begin
            $display("Timed out waiting for o_data_req to rise");
            errors++;
            return;
        end
        for (int x = 0; x < lw; x++) begin
            if (gaps) begin
                idle = int'($urandom_range(3, 0));
                repeat (idle) tick();
            end
            i_data     = line_px[x];
            i_data_vld = 1'b1;
            tick();
            i_data_vld = 1'b0;
        end
        i_data = '0;
        check_flag("o_data_req", o_data_req, 1'b0);
    endtask

    task automatic wait_done();
        int wait_cnt;
        wait_cnt = 0;
        while (o_done !== 1'b1 && wait_cnt < TIMEOUT_CYCLES) begin
            tick();
            wait_cnt++;
        end
        if (o_done !== 1'b1) begin
            $display("Timed out waiting for o_done to rise");
            errors++;
        end
        if (exp_psum.size() != 0) begin
            $display("%0d expected results never appeared", exp_psum.size());
            errors++;
            exp_psum.delete();
            exp_end.delete();
        end
    endtask

    task automatic run_line(input int lw, input int kw, input bit gaps);
        build_expected(lw, kw);
        start_line(lw, kw);
        load_weights(kw);
        send_line(lw, gaps);
        wait_done();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_mark);
        end
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic idle_strobes_ignored();
        test_mark = errors;
        fill_random();
        for (int i = 0; i < 6; i++) begin
            i_data       = line_px[i];
            i_data_vld   = 1'b1;
            i_weight_vld = 1'b1;
            tick();
            check_flag("o_weight_req", o_weight_req, 1'b0);
            check_flag("o_data_req", o_data_req, 1'b0);
            check_flag("o_psum_vld", o_psum_vld, 1'b0);
            check_flag("o_done", o_done, 1'b0);
        end
        i_data_vld   = 1'b0;
        i_weight_vld = 1'b0;
        i_data       = '0;
        // Any stray result would reach the monitor here
        repeat (5) tick();
        report_test("quiet before start");
    endtask

    task automatic wide_kernel_line();
        test_mark = errors;
        fill_random();
        run_line(8, 3, 1'b0);
        report_test("kernel 3, line 8");
    endtask

    task automatic single_tap_line();
        test_mark = errors;
        fill_random();
        run_line(5, 1, 1'b0);
        report_test("kernel 1, line 5");
    endtask

    task automatic wrapping_sums();
        test_mark = errors;
        fill_extremes();
        run_line(10, 2, 1'b0);
        report_test("wrapping sums");
    endtask

    task automatic gapped_input();
        test_mark = errors;
        fill_random();
        run_line(8, 3, 1'b0);
        run_line(8, 3, 1'b1);
        report_test("input gaps");
    endtask

    task automatic restart_after_done();
        test_mark = errors;
        fill_random();
        run_line(6, 3, 1'b0);
        check_flag("o_done", o_done, 1'b1);
        // New taps, stale slots 1 and 2 must not leak in
        fill_random();
        build_expected(4, 1);
        start_line(4, 1);
        check_flag("o_done", o_done, 1'b0);
        load_weights(1);
        send_line(4, 1'b0);
        wait_done();
        report_test("restart after done");
    endtask

    initial begin
        void'($urandom(32'h0a81_381b));
        errors       = 0;
        test_mark    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        i_start      = 1'b0;
        i_cfg        = '0;
        i_weight     = '0;
        i_weight_vld = 1'b0;
        i_data       = '0;
        i_data_vld   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        idle_strobes_ignored();
        wide_kernel_line();
        single_tap_line();
        wrapping_sums();
        gapped_input();
        restart_after_done();

        repeat (4) tick();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
src/conv_types_pkg.sv
src/conv_cfg_pkg.sv
src/conv_controller.sv
src/weight_buffer.sv
src/input_window.sv
src/kernel_channel_pe.sv
src/result_router.sv
src/line_conv_engine.sv
sim/tb_line_conv_engine.sv

/* Makefile */
TOP := tb_line_conv_engine

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^=== PASS ===$$" sim.log || (echo "Simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir sim.log
